// File: design/hbm_ctrl_fsm.sv
// ######################################################################
// HBM controller FSM
// Sequences the store clearing sweep, ready operation and periodic
// refresh windows, and raises busy outside the ready state.
// ######################################################################

module hbm_ctrl_fsm #(
  parameter int unsigned MEM_DEPTH        = 64,
  parameter int unsigned REFRESH_INTERVAL = 200,
  parameter int unsigned REFRESH_CYCLES   = 8,
  localparam int unsigned SPAN_A = (MEM_DEPTH > REFRESH_INTERVAL) ? MEM_DEPTH
                                                                  : REFRESH_INTERVAL,
  localparam int unsigned SPAN   = (SPAN_A > REFRESH_CYCLES) ? SPAN_A : REFRESH_CYCLES,
  localparam int unsigned CNT_W  = (SPAN > 1) ? $clog2(SPAN) : 1
) (
  input  logic                 rst_ni,
  input  logic                 rst_n_i,
  input  logic                 timer_done_i,
  output logic                 timer_load_o,
  output logic [CNT_W-1:0]     timer_value_o,
  output logic                 clear_en_o,
  output hbm_pkg::addr_t       clear_addr_o,
  output logic                 busy_o
);

  hbm_pkg::ctrl_state_e state_q;
  hbm_pkg::ctrl_state_e state_d;
  hbm_pkg::addr_t       clear_addr_q;
  logic                 sweep_start;

  // The timer comes out of reset at zero, so the sweep arms it on its
  // first cycle and ignores that first done
  assign sweep_start = (state_q == hbm_pkg::ST_CLEAR) && (clear_addr_q == '0);

  always_comb begin
    state_d       = state_q;
    timer_load_o  = 1'b0;
    timer_value_o = CNT_W'(MEM_DEPTH - 2);
    case (state_q)
      hbm_pkg::ST_CLEAR: begin
        if (sweep_start) begin
          timer_load_o = 1'b1;
        end else if (timer_done_i) begin
          state_d       = hbm_pkg::ST_READY;
          timer_load_o  = 1'b1;
          timer_value_o = CNT_W'(REFRESH_INTERVAL - 1);
        end
      end
      hbm_pkg::ST_READY: begin
        if (timer_done_i) begin
          state_d       = hbm_pkg::ST_REFRESH;
          timer_load_o  = 1'b1;
          timer_value_o = CNT_W'(REFRESH_CYCLES - 1);
        end
      end
      hbm_pkg::ST_REFRESH: begin
        if (timer_done_i) begin
          state_d       = hbm_pkg::ST_READY;
          timer_load_o  = 1'b1;
          timer_value_o = CNT_W'(REFRESH_INTERVAL - 1);
        end
      end
      default: begin
        state_d = hbm_pkg::ST_CLEAR;
      end
    endcase
  end

  always_ff @(posedge rst_ni) begin
    if (!rst_n_i) begin
      state_q <= hbm_pkg::ST_CLEAR;
    end else begin
      state_q <= state_d;
    end
  end

  // Sweep address, one word per cycle while clearing
  always_ff @(posedge rst_ni) begin
    if (!rst_n_i) begin
      clear_addr_q <= '0;
    end else if (state_q == hbm_pkg::ST_CLEAR) begin
      clear_addr_q <= clear_addr_q + 1'b1;
    end
  end

  assign clear_en_o   = (state_q == hbm_pkg::ST_CLEAR);
  assign clear_addr_o = clear_addr_q;
  assign busy_o       = (state_q != hbm_pkg::ST_READY);

endmodule

// File: design/hbm_cycle_timer.sv
// ######################################################################
// HBM cycle timer
// Loadable down-counter that holds at zero and flags done there.
// ######################################################################

module hbm_cycle_timer #(
  parameter int unsigned CNT_W = 8
) (
  input  logic             rst_ni,
  input  logic             rst_n_i,
  input  logic             load_i,
  input  logic [CNT_W-1:0] value_i,
  output logic             done_o
);

  logic [CNT_W-1:0] count_q;

  always_ff @(posedge rst_ni) begin
    if (!rst_n_i) begin
      count_q <= '0;
    end else if (load_i) begin
      count_q <= value_i;
    end else if (count_q != '0) begin
      count_q <= count_q - 1'b1;
    end
  end

  // Level, valid in the same cycle the count hits zero
  assign done_o = (count_q == '0);

endmodule

// File: design/hbm_delay_line.sv
// ######################################################################
// HBM response delay line
// Fixed-length shift pipeline for responses, one entry per stage,
// so every stage may carry a live response.
// ######################################################################

module hbm_delay_line #(
  parameter int unsigned STAGES = 5
) (
  input  logic           rst_ni,
  input  logic           rst_n_i,
  input  logic           valid_i,
  input  logic           write_i,
  input  hbm_pkg::data_t data_i,
  output logic           valid_o,
  output logic           write_o,
  output hbm_pkg::data_t data_o
);

  if (STAGES == 0) begin : gen_bypass

    // Store register already gives the full latency
    assign valid_o = valid_i;
    assign write_o = write_i;
    assign data_o  = data_i;

  end else begin : gen_pipe

    logic [STAGES-1:0] valid_q;
    logic [STAGES-1:0] write_q;
    hbm_pkg::data_t    data_q [STAGES];

    always_ff @(posedge rst_ni) begin
      if (!rst_n_i) begin
        valid_q <= '0;
      end else begin
        valid_q[0] <= valid_i;
        for (int i = 1; i < STAGES; i++) begin
          valid_q[i] <= valid_q[i-1];
        end
      end
    end

    // Payload shifts every cycle, qualified by valid
    always_ff @(posedge rst_ni) begin
      write_q[0] <= write_i;
      data_q[0]  <= data_i;
      for (int i = 1; i < STAGES; i++) begin
        write_q[i] <= write_q[i-1];
        data_q[i]  <= data_q[i-1];
      end
    end

    assign valid_o = valid_q[STAGES-1];
    assign write_o = write_q[STAGES-1];
    assign data_o  = data_q[STAGES-1];

  end

endmodule

// File: design/hbm_mem_array.sv
// ######################################################################
// HBM word store
// Single-port memory with a registered read. Takes either a clear
// write from the sweep or an accepted user request.
// ######################################################################

module hbm_mem_array #(
  parameter int unsigned MEM_DEPTH = 64
) (
  input  logic           rst_ni,
  input  logic           clear_en_i,
  input  hbm_pkg::addr_t clear_addr_i,
  input  logic           acc_i,
  input  logic           write_i,
  input  hbm_pkg::addr_t addr_i,
  input  hbm_pkg::data_t wdata_i,
  output hbm_pkg::data_t rdata_o,
  output logic           valid_o,
  output logic           write_o
);

  localparam int unsigned IDX_W = $clog2(MEM_DEPTH);

  hbm_pkg::data_t   mem_q [MEM_DEPTH];
  hbm_pkg::data_t   rdata_q;
  logic             valid_q;
  logic             write_q;
  logic [IDX_W-1:0] clear_idx;
  logic [IDX_W-1:0] req_idx;

  // Only the low address bits select a word
  assign clear_idx = clear_addr_i[IDX_W-1:0];
  assign req_idx   = addr_i[IDX_W-1:0];

  // Clear and accept never overlap, the sweep runs while busy
  always_ff @(posedge rst_ni) begin
    if (clear_en_i) begin
      mem_q[clear_idx] <= '0;
    end else if (acc_i && write_i) begin
      mem_q[req_idx] <= wdata_i;
    end
  end

  // Old word is captured, also for writes
  always_ff @(posedge rst_ni) begin
    valid_q <= acc_i;
    if (acc_i) begin
      rdata_q <= mem_q[req_idx];
      write_q <= write_i;
    end
  end

  assign rdata_o = rdata_q;
  assign valid_o = valid_q;
  assign write_o = write_q;

endmodule

// File: design/hbm_model_top.sv
// ######################################################################
// HBM memory model
// Single-channel controller model with fixed response latency,
// clearing sweep after reset and periodic refresh windows.
// ######################################################################

module hbm_model_top #(
  parameter int unsigned LATENCY          = 6,
  parameter int unsigned MEM_DEPTH        = 64,
  parameter int unsigned REFRESH_INTERVAL = 200,
  parameter int unsigned REFRESH_CYCLES   = 8
) (
  input  logic           rst_ni,
  input  logic           rst_n_i,
  input  logic           req_valid_i,
  input  logic           req_write_i,
  input  hbm_pkg::addr_t req_addr_i,
  input  hbm_pkg::data_t req_wdata_i,
  output logic           busy_o,
  output logic           rsp_valid_o,
  output logic           rsp_write_o,
  output hbm_pkg::data_t rsp_rdata_o
);

  // Timer must hold the longest of the three phase lengths
  localparam int unsigned SPAN_A = (MEM_DEPTH > REFRESH_INTERVAL) ? MEM_DEPTH
                                                                  : REFRESH_INTERVAL;
  localparam int unsigned SPAN   = (SPAN_A > REFRESH_CYCLES) ? SPAN_A : REFRESH_CYCLES;
  localparam int unsigned CNT_W  = (SPAN > 1) ? $clog2(SPAN) : 1;

  logic             acc;
  logic             timer_load;
  logic [CNT_W-1:0] timer_value;
  logic             timer_done;
  logic             clear_en;
  hbm_pkg::addr_t   clear_addr;
  logic             mem_valid;
  logic             mem_write;
  hbm_pkg::data_t   mem_rdata;

  // Single place where strobes are qualified
  assign acc = req_valid_i && !busy_o;

  hbm_ctrl_fsm #(
    .MEM_DEPTH        (MEM_DEPTH),
    .REFRESH_INTERVAL (REFRESH_INTERVAL),
    .REFRESH_CYCLES   (REFRESH_CYCLES)
  ) u_hbm_ctrl_fsm (
    .rst_ni        (rst_ni),
    .rst_n_i       (rst_n_i),
    .timer_done_i  (timer_done),
    .timer_load_o  (timer_load),
    .timer_value_o (timer_value),
    .clear_en_o    (clear_en),
    .clear_addr_o  (clear_addr),
    .busy_o        (busy_o)
  );

  hbm_cycle_timer #(
    .CNT_W (CNT_W)
  ) u_hbm_cycle_timer (
    .rst_ni  (rst_ni),
    .rst_n_i (rst_n_i),
    .load_i  (timer_load),
    .value_i (timer_value),
    .done_o  (timer_done)
  );

  hbm_mem_array #(
    .MEM_DEPTH (MEM_DEPTH)
  ) u_hbm_mem_array (
    .rst_ni       (rst_ni),
    .clear_en_i   (clear_en),
    .clear_addr_i (clear_addr),
    .acc_i        (acc),
    .write_i      (req_write_i),
    .addr_i       (req_addr_i),
    .wdata_i      (req_wdata_i),
    .rdata_o      (mem_rdata),
    .valid_o      (mem_valid),
    .write_o      (mem_write)
  );

  // Store adds one cycle, the line adds the rest
  hbm_delay_line #(
    .STAGES (LATENCY - 1)
  ) u_hbm_delay_line (
    .rst_ni  (rst_ni),
    .rst_n_i (rst_n_i),
    .valid_i (mem_valid),
    .write_i (mem_write),
    .data_i  (mem_rdata),
    .valid_o (rsp_valid_o),
    .write_o (rsp_write_o),
    .data_o  (rsp_rdata_o)
  );

endmodule

// File: design/hbm_pkg.sv
// ######################################################################
// HBM model package
// Word and address widths, their vector types and the controller
// state encoding shared by the memory model blocks.
// ######################################################################

package hbm_pkg;

  // Word address width, enough for 1024 words
  localparam int unsigned ADDR_W = 10;

  // Stored word width
  localparam int unsigned DATA_W = 32;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] data_t;

  // Controller phases
  typedef enum logic [1:0] {
    ST_CLEAR   = 2'd0,
    ST_READY   = 2'd1,
    ST_REFRESH = 2'd2
  } ctrl_state_e;

endpackage

// File: run_sim.sh
#!/bin/sh
# Build the HBM model testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f vlog.f --top-module hbm_model_tb -o hbm_model_sim

status=0
out=$(./obj_dir/hbm_model_sim) || status=$?
echo "$out"

if [ "$status" -eq 0 ] && echo "$out" | grep -qx "Verification passed"; then
  exit 0
fi
exit 1

// File: verification/hbm_model_properties.sv
// ######################################################################
// HBM model assertions
// Bound to the model top level. Checks response origin, busy versus
// controller state and the refresh window length.
// ######################################################################

module hbm_model_properties #(
  parameter int unsigned LATENCY        = 6,
  parameter int unsigned REFRESH_CYCLES = 8
) (
  input logic                 rst_ni,
  input logic                 rst_n_i,
  input logic                 req_valid_i,
  input logic                 busy_o,
  input logic                 rsp_valid_o,
  input hbm_pkg::ctrl_state_e state_i
);

  timeunit 1ns;
  timeprecision 1ps;

  int unsigned busy_run_q;

  // Length of the current busy stretch
  always_ff @(posedge rst_ni) begin
    if (!rst_n_i) begin
      busy_run_q <= 0;
    end else if (busy_o) begin
      busy_run_q <= busy_run_q + 1;
    end else begin
      busy_run_q <= 0;
    end
  end

  a_rsp_has_accept: assert property (@(posedge rst_ni) disable iff (!rst_n_i)
    rsp_valid_o |-> $past(req_valid_i && !busy_o, LATENCY))
    else $error("response without an accepted request");

  a_busy_rise_in_refresh: assert property (@(posedge rst_ni) disable iff (!rst_n_i)
    $rose(busy_o) |-> (state_i == hbm_pkg::ST_REFRESH))
    else $error("busy rose outside a refresh window");

  a_refresh_length: assert property (@(posedge rst_ni) disable iff (!rst_n_i)
    ($fell(busy_o) && $past(state_i) == hbm_pkg::ST_REFRESH)
      |-> busy_run_q == REFRESH_CYCLES)
    else $error("refresh window has the wrong length");

endmodule

bind hbm_model_top hbm_model_properties #(
  .LATENCY        (LATENCY),
  .REFRESH_CYCLES (REFRESH_CYCLES)
) u_hbm_model_properties (
  .rst_ni      (rst_ni),
  .rst_n_i     (rst_n_i),
  .req_valid_i (req_valid_i),
  .busy_o      (busy_o),
  .rsp_valid_o (rsp_valid_o),
  .state_i     (u_hbm_ctrl_fsm.state_q)
);

// File: verification/hbm_model_tb.sv
// ######################################################################
// HBM model testbench
// Drives random reads and writes, models the store and checks every
// response for order, latency, write flag and read data.
// ######################################################################

module hbm_model_tb;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned LATENCY          = 6;
  localparam int unsigned MEM_DEPTH        = 64;
  localparam int unsigned REFRESH_INTERVAL = 200;
  localparam int unsigned REFRESH_CYCLES   = 8;
  localparam int unsigned IDX_W            = $clog2(MEM_DEPTH);
  localparam int unsigned RESET_CYCLES     = 3;
  localparam int unsigned N_CLEAR_READS    = 16;
  localparam int unsigned N_PIPE           = 150;
  // Sweep, all tests and up to four refresh periods of waiting plus margin
  localparam int unsigned TIMEOUT_CYCLES = 3 * (RESET_CYCLES + MEM_DEPTH + N_CLEAR_READS + 2
    + N_PIPE + 4 * (REFRESH_INTERVAL + REFRESH_CYCLES));

  logic           rst_ni;
  logic           rst_n_i;
  logic           req_valid_i;
  logic           req_write_i;
  hbm_pkg::addr_t req_addr_i;
  hbm_pkg::data_t req_wdata_i;
  logic           busy_o;
  logic           rsp_valid_o;
  logic           rsp_write_o;
  hbm_pkg::data_t rsp_rdata_o;

  hbm_pkg::data_t ref_mem [MEM_DEPTH];
  int unsigned    exp_cycle_q [$];
  logic           exp_write_q [$];
  hbm_pkg::data_t exp_data_q [$];
  int unsigned    exp_test_q [$];
  hbm_pkg::addr_t ign_q [$];
  string          test_names [5];
  int unsigned    test_idx;
  int unsigned    cycle_cnt;
  int unsigned    error_cnt;
  int unsigned    check_cnt;
  int unsigned    tests_run;
  logic [31:0]    rng;
  int unsigned    head_cycle;
  logic           head_write;
  hbm_pkg::data_t head_data;
  int unsigned    head_test;

  hbm_model_top #(
    .LATENCY          (LATENCY),
    .MEM_DEPTH        (MEM_DEPTH),
    .REFRESH_INTERVAL (REFRESH_INTERVAL),
    .REFRESH_CYCLES   (REFRESH_CYCLES)
  ) u_hbm_model_top (
    .rst_ni      (rst_ni),
    .rst_n_i     (rst_n_i),
    .req_valid_i (req_valid_i),
    .req_write_i (req_write_i),
    .req_addr_i  (req_addr_i),
    .req_wdata_i (req_wdata_i),
    .busy_o      (busy_o),
    .rsp_valid_o (rsp_valid_o),
    .rsp_write_o (rsp_write_o),
    .rsp_rdata_o (rsp_rdata_o)
  );

  always #5 rst_ni = ~rst_ni;

  always @(posedge rst_ni) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Verification failed");
      $finish;
    end
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Old word at the address as a read or a write sees it
  function automatic hbm_pkg::data_t expected_read(input hbm_pkg::addr_t a);
    return ref_mem[a[IDX_W-1:0]];
  endfunction

  task automatic next_rand(output logic [31:0] r);
    rng = lcg_next(rng);
    r = rng;
  endtask

  // Drive in the current cycle while busy is known to be low
  task automatic drive_now(input logic wr, input hbm_pkg::addr_t a, input hbm_pkg::data_t d);
    req_valid_i = 1'b1;
    req_write_i = wr;
    req_addr_i  = a;
    req_wdata_i = d;
    exp_cycle_q.push_back(cycle_cnt);
    exp_write_q.push_back(wr);
    exp_data_q.push_back(expected_read(a));
    exp_test_q.push_back(test_idx);
    if (wr) begin
      ref_mem[a[IDX_W-1:0]] = d;
    end
  endtask

  task automatic send_req(input logic wr, input hbm_pkg::addr_t a, input hbm_pkg::data_t d);
    @(negedge rst_ni);
    req_valid_i = 1'b0;
    while (busy_o) begin
      @(negedge rst_ni);
    end
    drive_now(wr, a, d);
  endtask

  task automatic send_random(input logic allow_write);
    logic [31:0] ra;
    logic [31:0] rd;
    next_rand(ra);
    next_rand(rd);
    send_req(allow_write & ra[31], hbm_pkg::addr_t'(ra % MEM_DEPTH), rd);
  endtask

  task automatic release_and_drain();
    @(negedge rst_ni);
    req_valid_i = 1'b0;
    while (exp_cycle_q.size() != 0) begin
      @(negedge rst_ni);
    end
  endtask

  task automatic end_test(input int unsigned err_start);
    tests_run++;
    if (error_cnt == err_start) begin
      $display("Test %s: PASS", test_names[test_idx]);
    end else begin
      $display("Test %s: FAIL with %0d errors", test_names[test_idx], error_cnt - err_start);
    end
  endtask

  // Response checker sampling at the falling edge where outputs are stable
  always @(negedge rst_ni) begin
    if (rst_n_i && rsp_valid_o) begin
      if (exp_cycle_q.size() == 0) begin
        $display("Response at cycle %0d with no request outstanding", cycle_cnt);
        error_cnt++;
      end else begin
        head_cycle = exp_cycle_q.pop_front();
        head_write = exp_write_q.pop_front();
        head_data  = exp_data_q.pop_front();
        head_test  = exp_test_q.pop_front();
        check_cnt++;
        if (cycle_cnt != head_cycle + LATENCY) begin
          $display("** Error %s latency: expected %0d actual %0d", test_names[head_test],
                   LATENCY, cycle_cnt - head_cycle);
          error_cnt++;
        end
        if (rsp_write_o !== head_write) begin
          $display("** Error %s write flag: expected %0b actual %0b", test_names[head_test],
                   head_write, rsp_write_o);
          error_cnt++;
        end
        if (!head_write && rsp_rdata_o !== head_data) begin
          $display("** Error %s read data: expected %h actual %h", test_names[head_test],
                   head_data, rsp_rdata_o);
          error_cnt++;
        end
      end
    end
  end

  initial begin
    int unsigned err_start;
    int unsigned wait_len;
    int unsigned busy_len;
    int unsigned ready_len;
    logic [31:0] r;
    hbm_pkg::addr_t a;

    rst_ni      = 1'b0;
    rst_n_i     = 1'b0;
    req_valid_i = 1'b0;
    req_write_i = 1'b0;
    req_addr_i  = '0;
    req_wdata_i = '0;
    cycle_cnt   = 0;
    error_cnt   = 0;
    check_cnt   = 0;
    tests_run   = 0;
    rng         = 32'h409d3071;
    for (int i = 0; i < MEM_DEPTH; i++) begin
      ref_mem[i] = '0;
    end
    test_names = '{"clear_on_reset", "write_then_read", "pipelined_traffic",
                   "refresh_windows", "ignored_strobes"};

    repeat (RESET_CYCLES) @(posedge rst_ni);
    @(negedge rst_ni);
    rst_n_i = 1'b1;

    // Clear sweep followed by reads of a zeroed store
    test_idx  = 0;
    err_start = error_cnt;
    @(negedge rst_ni);
    if (busy_o !== 1'b1) begin
      $display("** Error %s busy after reset: expected 1 actual %b",
               test_names[test_idx], busy_o);
      error_cnt++;
    end
    wait_len = 0;
    while (busy_o) begin
      @(negedge rst_ni);
      wait_len++;
    end
    if (wait_len > MEM_DEPTH + 4) begin
      $display("Busy stayed high for %0d cycles after reset", wait_len);
      error_cnt++;
    end
    repeat (N_CLEAR_READS) send_random(1'b0);
    release_and_drain();
    end_test(err_start);

    test_idx  = 1;
    err_start = error_cnt;
    next_rand(r);
    a = hbm_pkg::addr_t'(r % MEM_DEPTH);
    next_rand(r);
    send_req(1'b1, a, r);
    send_req(1'b0, a, '0);
    release_and_drain();
    end_test(err_start);

    test_idx  = 2;
    err_start = error_cnt;
    repeat (N_PIPE) send_random(1'b1);
    release_and_drain();
    end_test(err_start);

    // Fill the pipe up to the refresh edge and then time both phases
    test_idx  = 3;
    err_start = error_cnt;
    while (busy_o) begin
      @(negedge rst_ni);
    end
    while (!busy_o) begin
      next_rand(r);
      drive_now(1'b0, hbm_pkg::addr_t'(r % MEM_DEPTH), '0);
      @(negedge rst_ni);
    end
    req_valid_i = 1'b0;
    busy_len = 0;
    while (busy_o) begin
      busy_len++;
      @(negedge rst_ni);
    end
    if (busy_len != REFRESH_CYCLES) begin
      $display("** Error refresh_windows busy length: expected %0d actual %0d",
               REFRESH_CYCLES, busy_len);
      error_cnt++;
    end
    ready_len = 0;
    while (!busy_o) begin
      ready_len++;
      @(negedge rst_ni);
    end
    if (ready_len != REFRESH_INTERVAL) begin
      $display("** Error refresh_windows ready length: expected %0d actual %0d",
               REFRESH_INTERVAL, ready_len);
      error_cnt++;
    end
    release_and_drain();
    end_test(err_start);

    // Writes strobed during refresh must vanish
    test_idx  = 4;
    err_start = error_cnt;
    while (!busy_o) begin
      @(negedge rst_ni);
    end
    while (busy_o) begin
      next_rand(r);
      a = hbm_pkg::addr_t'(r % MEM_DEPTH);
      next_rand(r);
      req_valid_i = 1'b1;
      req_write_i = 1'b1;
      req_addr_i  = a;
      req_wdata_i = r;
      ign_q.push_back(a);
      @(negedge rst_ni);
    end
    req_valid_i = 1'b0;
    foreach (ign_q[i]) begin
      send_req(1'b0, ign_q[i], '0);
    end
    release_and_drain();
    repeat (LATENCY + 2) @(negedge rst_ni);
    end_test(err_start);

    $display("Tests run: %0d, responses checked: %0d, errors: %0d",
             tests_run, check_cnt, error_cnt);
    if (error_cnt == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

// File: vlog.f
design/hbm_pkg.sv
design/hbm_ctrl_fsm.sv
design/hbm_cycle_timer.sv
design/hbm_mem_array.sv
design/hbm_delay_line.sv
design/hbm_model_top.sv
verification/hbm_model_properties.sv
verification/hbm_model_tb.sv
